// ==== src.f ====
+incdir+include
design/sbuf_pkg.sv
design/sbuf_ram_if.sv
design/sbuf_tdp_ram.sv
design/sbuf_capture.sv
design/sbuf_csr.sv
design/sample_buffer.sv
sim/sample_buffer_checker.sv
sim/sample_buffer_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sample buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module sample_buffer_tb -f src.f --Mdir obj_dir

out=$(./obj_dir/Vsample_buffer_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

// ==== sim/sample_buffer_tb.sv ====
`timescale 1ns/1ns
`include "sbuf_params.svh"

module sample_buffer_tb;

  localparam int EXPECTED_CYCLES = 6000;
  localparam int TIMEOUT_CYCLES = 3 * EXPECTED_CYCLES + 2000;
  localparam int BUF_BASE = 1 << (`SBUF_REG_ADDR_W - 1);  // Buffer window

  logic                        stream_in;
  logic                        rst;
  logic                        trigger;
  logic                        s_valid;
  logic [`SBUF_DATA_W-1:0]     s_data;
  logic                        s_ready;
  logic                        req_valid;
  logic                        req_ready;
  logic                        req_write;
  logic [`SBUF_REG_ADDR_W-1:0] req_addr;
  logic [`SBUF_DATA_W-1:0]     req_wdata;
  logic                        resp_valid;
  logic                        resp_ready;
  logic [`SBUF_DATA_W-1:0]     resp_rdata;

  // Reference model
  sbuf_pkg::sample_t exp_buf [`SBUF_DEPTH];
  bit                exp_known [`SBUF_DEPTH];
  sbuf_pkg::offset_t exp_addr;
  sbuf_pkg::offset_t start_ofs;
  sbuf_pkg::offset_t end_ofs;
  logic [2:0]        ctl;
  logic              exp_wrap;
  logic              exp_en;
  logic              exp_armed;

  sbuf_pkg::sample_t exp_q [$];
  sbuf_pkg::sample_t exp_v;
  logic [31:0]       seed;
  logic              stall_en;
  logic              rd_pending = 1'b0;
  string             test_name;
  int                errors = 0;
  int                checks = 0;
  int                cycles = 0;
  int                taken;

  sample_buffer sample_buffer_i (.*);

  always #2 stream_in = ~stream_in;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic pick_ready();
    if (!stall_en) begin
      return 1'b1;
    end
    seed = lcg(seed);
    return seed[31];  // Half the cycles stalled
  endfunction

  function automatic sbuf_pkg::sample_t expected_read(input sbuf_pkg::reg_addr_t addr);
    sbuf_pkg::sample_t v;
    v = '0;
    if (addr[`SBUF_REG_ADDR_W-1]) begin
      v = exp_buf[sbuf_pkg::offset_t'(addr)];
    end else begin
      case (int'(addr))
        `SBUF_REG_CONTROL: v = sbuf_pkg::sample_t'(ctl);
        `SBUF_REG_START:   v = sbuf_pkg::sample_t'(start_ofs);
        `SBUF_REG_END:     v = sbuf_pkg::sample_t'(end_ofs);
        `SBUF_REG_STATUS: begin
          v[0]    = ~exp_en;
          v[1]    = exp_armed;
          v[2]    = exp_wrap;
          v[15:8] = exp_addr;
        end
        `SBUF_REG_DEPTH:   v = `SBUF_DEPTH;
        default:           v = '0;
      endcase
    end
    return v;
  endfunction

  function void apply_sample(input sbuf_pkg::sample_t d);
    exp_buf[exp_addr] = d;
    exp_known[exp_addr] = 1'b1;
    if (exp_addr == end_ofs) begin
      exp_addr = start_ofs;
      exp_wrap = ~exp_wrap;
      if (ctl[`SBUF_CTRL_ONE_SHOT]) begin
        exp_en = 1'b0;
      end
    end else begin
      exp_addr = exp_addr + 1'b1;
    end
  endfunction

  function void apply_control();
    exp_en    = ctl[`SBUF_CTRL_ACTIVE] & ~ctl[`SBUF_CTRL_WAIT_TRIG];
    exp_armed = ctl[`SBUF_CTRL_ACTIVE] & ctl[`SBUF_CTRL_WAIT_TRIG];
    if (ctl[`SBUF_CTRL_ACTIVE]) begin
      exp_addr = start_ofs;
    end
  endfunction

  task automatic reg_write(input int addr, input int data);
    @(negedge stream_in);
    req_valid = 1'b1;
    req_write = 1'b1;
    req_addr  = sbuf_pkg::reg_addr_t'(addr);
    req_wdata = data;
    while (!req_ready) @(negedge stream_in);
    @(negedge stream_in);
    req_valid = 1'b0;
    case (addr)
      `SBUF_REG_START: start_ofs = sbuf_pkg::offset_t'(data);
      `SBUF_REG_END:   end_ofs = sbuf_pkg::offset_t'(data);
      `SBUF_REG_CONTROL: begin
        ctl = data[2:0];
        apply_control();
      end
      default: ;
    endcase
    repeat (3) @(negedge stream_in);  // Engine settles at N+2
  endtask

  task automatic reg_read(input int addr);
    @(negedge stream_in);
    req_valid = 1'b1;
    req_write = 1'b0;
    req_addr  = sbuf_pkg::reg_addr_t'(addr);
    while (!req_ready) @(negedge stream_in);
    exp_q.push_back(expected_read(req_addr));
    @(negedge stream_in);
    req_valid  = 1'b0;
    resp_ready = pick_ready();
    while (!(resp_valid && resp_ready)) begin
      @(negedge stream_in);
      resp_ready = pick_ready();
    end
    @(negedge stream_in);
    resp_ready = 1'b0;
  endtask

  task automatic read_range(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      reg_read(BUF_BASE + i);
    end
  endtask

  // density is the share of valid cycles out of 16
  task automatic stream_samples(input int n, input int max_cycles, input int density);
    int c;
    c = 0;
    taken = 0;
    while (taken < n && c < max_cycles) begin
      @(negedge stream_in);
      seed = lcg(seed);
      s_valid = int'(seed[31:28]) < density;
      seed = lcg(seed);
      s_data = seed;
      if (s_valid && s_ready) begin  // Taken at the next rising edge
        apply_sample(s_data);
        taken++;
      end
      c++;
    end
    @(negedge stream_in);
    s_valid = 1'b0;
  endtask

  // A read stays pending from acceptance until its response is taken
  always @(posedge stream_in) begin
    if (!rst && req_valid && req_ready) begin
      if (rd_pending) begin
        errors++;
        $display("%s: request accepted while a read was still outstanding", test_name);
      end
      if (!req_write) begin
        rd_pending = 1'b1;
      end
    end
    if (!rst && resp_valid && resp_ready) begin
      rd_pending = 1'b0;
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: response arrived with no read outstanding", test_name);
      end else begin
        exp_v = exp_q.pop_front();
        checks++;
        if (resp_rdata !== exp_v) begin
          errors++;
          $display("Fail %s expected %h actual %h", test_name, exp_v, resp_rdata);
        end
      end
    end
  end

  always @(posedge stream_in) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    stream_in  = 1'b0;
    rst        = 1'b1;
    trigger    = 1'b0;
    s_valid    = 1'b0;
    s_data     = '0;
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    resp_ready = 1'b0;
    seed       = 32'hf7c5;
    stall_en   = 1'b0;
    exp_addr   = '0;
    start_ofs  = '0;
    end_ofs    = sbuf_pkg::offset_t'(`SBUF_DEPTH - 1);
    ctl        = '0;
    exp_wrap   = 1'b0;
    exp_en     = 1'b0;
    exp_armed  = 1'b0;
    repeat (16) @(posedge stream_in);
    @(negedge stream_in);
    rst = 1'b0;

    test_name = "reset";
    if (s_ready !== 1'b0) begin
      errors++;
      $display("Fail %s s_ready expected 0 actual %b", test_name, s_ready);
    end
    for (int r = 0; r <= `SBUF_REG_DEPTH; r++) begin
      reg_read(r);
    end

    test_name = "one_shot";
    reg_write(`SBUF_REG_START, 16);
    reg_write(`SBUF_REG_END, 47);
    reg_write(`SBUF_REG_CONTROL, 3);
    stream_samples(40, 200, 12);
    if (taken != 32) begin
      errors++;
      $display("Fail %s samples expected 32 actual %0d", test_name, taken);
    end
    if (s_ready !== exp_en) begin
      errors++;
      $display("Fail %s s_ready expected %b actual %b", test_name, exp_en, s_ready);
    end
    read_range(16, 47);
    reg_read(`SBUF_REG_STATUS);

    test_name = "circular";
    reg_write(`SBUF_REG_START, 100);
    reg_write(`SBUF_REG_END, 109);
    reg_write(`SBUF_REG_CONTROL, 1);
    stream_samples(25, 400, 10);
    reg_write(`SBUF_REG_CONTROL, 0);
    read_range(100, 109);
    reg_read(`SBUF_REG_STATUS);

    test_name = "trigger";
    reg_write(`SBUF_REG_START, 200);
    reg_write(`SBUF_REG_END, 219);
    reg_write(`SBUF_REG_CONTROL, 5);
    stream_samples(10, 30, 16);
    if (taken != 0) begin
      errors++;
      $display("Fail %s samples expected 0 actual %0d", test_name, taken);
    end
    reg_read(`SBUF_REG_STATUS);
    @(negedge stream_in);
    trigger = 1'b1;
    @(negedge stream_in);
    trigger = 1'b0;
    repeat (2) @(negedge stream_in);
    exp_en    = 1'b1;
    exp_armed = 1'b0;
    if (s_ready !== exp_en) begin
      errors++;
      $display("Fail %s s_ready expected %b actual %b", test_name, exp_en, s_ready);
    end
    stream_samples(30, 400, 10);
    reg_write(`SBUF_REG_CONTROL, 0);
    read_range(200, 219);
    reg_read(`SBUF_REG_STATUS);

    test_name = "backpressure";
    stall_en = 1'b1;
    read_range(16, 47);
    read_range(100, 109);
    for (int r = 0; r <= `SBUF_REG_DEPTH; r++) begin
      reg_read(r);
    end

    // Overlaps the one-shot range whose other words stay as they were
    test_name = "retention";
    reg_write(`SBUF_REG_START, 40);
    reg_write(`SBUF_REG_END, 59);
    reg_write(`SBUF_REG_CONTROL, 3);
    stream_samples(20, 200, 12);
    for (int i = 0; i < `SBUF_DEPTH; i++) begin
      if (exp_known[i]) begin
        reg_read(BUF_BASE + i);
      end
    end
    reg_read(`SBUF_REG_STATUS);

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d read responses never arrived", exp_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sim/sample_buffer_checker.sv ====
`timescale 1ns/1ns

module sample_buffer_checker (
  input logic              stream_in,
  input logic              rst,
  input logic              s_valid,
  input logic              s_ready,
  input logic              req_valid,
  input logic              req_ready,
  input logic              req_write,
  input logic              resp_valid,
  input logic              resp_ready,
  input sbuf_pkg::sample_t resp_rdata,
  input logic              update,
  input sbuf_pkg::offset_t wr_addr
);

  resp_held: assert property (@(posedge stream_in) disable iff (rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
    else $error("Response dropped or changed before it was taken");

  // Requests held off from read acceptance until the response is up
  read_in_flight: assert property (@(posedge stream_in) disable iff (rst)
    req_valid && req_ready && !req_write |=>
      !req_ready ##1 !req_ready ##1 (resp_valid && !req_ready))
    else $error("Request bus ready while a read was in flight");

  ready_low_after_rst: assert property (@(posedge stream_in)
    rst |=> !s_ready)
    else $error("Stream ready high right after reset");

  // Address moves only on a sample or a control update
  addr_stable: assert property (@(posedge stream_in) disable iff (rst)
    !(s_valid && s_ready) && !update |=> $stable(wr_addr))
    else $error("Capture address changed with no sample and no update");

endmodule

bind sample_buffer sample_buffer_checker checker_i (
  .stream_in  (stream_in),
  .rst        (rst),
  .s_valid    (s_valid),
  .s_ready    (s_ready),
  .req_valid  (req_valid),
  .req_ready  (req_ready),
  .req_write  (req_write),
  .resp_valid (resp_valid),
  .resp_ready (resp_ready),
  .resp_rdata (resp_rdata),
  .update     (ctrl.update),
  .wr_addr    (stat.addr)
);

// ==== design/sample_buffer.sv ====
`timescale 1ns/1ns
`include "sbuf_params.svh"

module sample_buffer (
  input  logic                        stream_in,
  input  logic                        rst,
  input  logic                        trigger,
  // Sample stream
  input  logic                        s_valid,
  input  logic [`SBUF_DATA_W-1:0]     s_data,
  output logic                        s_ready,
  // Register bus
  input  logic                        req_valid,
  output logic                        req_ready,
  input  logic                        req_write,
  input  logic [`SBUF_REG_ADDR_W-1:0] req_addr,
  input  logic [`SBUF_DATA_W-1:0]     req_wdata,
  output logic                        resp_valid,
  input  logic                        resp_ready,
  output logic [`SBUF_DATA_W-1:0]     resp_rdata
);

  sbuf_pkg::capture_ctrl_t ctrl;
  sbuf_pkg::capture_stat_t stat;

  sbuf_ram_if mem_host ();
  sbuf_ram_if mem_stream ();

  sbuf_csr csr_i (
    .stream_in  (stream_in),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .ctrl       (ctrl),
    .stat       (stat),
    .mem        (mem_host.client)
  );

  sbuf_capture capture_i (
    .stream_in (stream_in),
    .rst       (rst),
    .ctrl      (ctrl),
    .trigger   (trigger),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_ready   (s_ready),
    .stat      (stat),
    .mem       (mem_stream.client)
  );

  sbuf_tdp_ram ram_i (
    .stream_in (stream_in),
    .a         (mem_host.ram_port),
    .b         (mem_stream.ram_port)
  );

endmodule

// ==== design/sbuf_csr.sv ====
`timescale 1ns/1ns
`include "sbuf_params.svh"

module sbuf_csr (
  input  logic                    stream_in,
  input  logic                    rst,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  logic                    req_write,
  input  sbuf_pkg::reg_addr_t     req_addr,
  input  sbuf_pkg::sample_t       req_wdata,
  output logic                    resp_valid,
  input  logic                    resp_ready,
  output sbuf_pkg::sample_t       resp_rdata,
  output sbuf_pkg::capture_ctrl_t ctrl,
  input  sbuf_pkg::capture_stat_t stat,
  sbuf_ram_if.client              mem
);

  localparam int BUF_BIT = `SBUF_REG_ADDR_W - 1;
  localparam int OFS_W = $bits(sbuf_pkg::offset_t);

  typedef logic [BUF_BIT-1:0] reg_num_t;

  logic                  running;  // Low through the first cycle after reset
  logic                  req_fire;
  logic                  wr_q;
  logic                  rd_q;
  logic                  rd_dly;
  sbuf_pkg::reg_addr_t   addr_q;
  sbuf_pkg::reg_addr_t   addr_dly;
  sbuf_pkg::sample_t     wdata_q;
  logic [2:0]            control;
  logic                  update;
  sbuf_pkg::offset_t     start_offset;
  sbuf_pkg::offset_t     end_offset;
  sbuf_pkg::status_reg_t status;
  sbuf_pkg::sample_t     reg_rdata;

  // One read in flight at a time and nothing accepted while a response waits
  assign req_ready = running & ~rd_q & ~rd_dly & ~resp_valid;
  assign req_fire  = req_valid & req_ready;

  always_ff @(posedge stream_in) begin
    if (rst) begin
      running <= 1'b0;
      wr_q    <= 1'b0;
      rd_q    <= 1'b0;
      rd_dly  <= 1'b0;
    end else begin
      running <= 1'b1;
      wr_q    <= req_fire & req_write;
      rd_q    <= req_fire & ~req_write;
      rd_dly  <= rd_q;
    end
  end

  always_ff @(posedge stream_in) begin
    if (req_fire) begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    addr_dly <= addr_q;
  end

  // Register writes land one cycle after acceptance
  always_ff @(posedge stream_in) begin
    if (rst) begin
      control      <= '0;
      update       <= 1'b0;
      start_offset <= '0;
      end_offset   <= sbuf_pkg::offset_t'(`SBUF_DEPTH - 1);
    end else begin
      update <= 1'b0;
      if (wr_q && !addr_q[BUF_BIT]) begin  // Buffer window is read only
        case (addr_q[BUF_BIT-1:0])
          reg_num_t'(`SBUF_REG_CONTROL): begin
            control <= wdata_q[2:0];
            update  <= 1'b1;
          end
          reg_num_t'(`SBUF_REG_START): start_offset <= wdata_q[OFS_W-1:0];
          reg_num_t'(`SBUF_REG_END):   end_offset   <= wdata_q[OFS_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign ctrl.update       = update;
  assign ctrl.active       = control[`SBUF_CTRL_ACTIVE];
  assign ctrl.one_shot     = control[`SBUF_CTRL_ONE_SHOT];
  assign ctrl.wait_trigger = control[`SBUF_CTRL_WAIT_TRIG];
  assign ctrl.start_offset = start_offset;
  assign ctrl.end_offset   = end_offset;

  // Port A is a read-only window onto the buffer
  assign mem.en    = rd_q & addr_q[BUF_BIT];
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_q[OFS_W-1:0];
  assign mem.wdata = '0;

  assign status = '{
    rsvd_hi:     '0,
    addr:        stat.addr,
    rsvd_lo:     '0,
    wrap_toggle: stat.wrap_toggle,
    armed:       stat.armed,
    stopped:     stat.stopped
  };

  always_comb begin
    case (addr_dly[BUF_BIT-1:0])
      reg_num_t'(`SBUF_REG_CONTROL): reg_rdata = sbuf_pkg::sample_t'(control);
      reg_num_t'(`SBUF_REG_START):   reg_rdata = sbuf_pkg::sample_t'(start_offset);
      reg_num_t'(`SBUF_REG_END):     reg_rdata = sbuf_pkg::sample_t'(end_offset);
      reg_num_t'(`SBUF_REG_STATUS):  reg_rdata = status;
      reg_num_t'(`SBUF_REG_DEPTH):   reg_rdata = sbuf_pkg::sample_t'(`SBUF_DEPTH);
      default:                       reg_rdata = '0;
    endcase
  end

  // Response register held until taken
  always_ff @(posedge stream_in) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else if (rd_dly) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge stream_in) begin
    if (rd_dly) begin
      resp_rdata <= addr_dly[BUF_BIT] ? mem.rdata : reg_rdata;
    end
  end

endmodule

// ==== design/sbuf_capture.sv ====
`timescale 1ns/1ns

module sbuf_capture (
  input  logic                    stream_in,
  input  logic                    rst,
  input  sbuf_pkg::capture_ctrl_t ctrl,
  input  logic                    trigger,
  input  logic                    s_valid,
  input  sbuf_pkg::sample_t       s_data,
  output logic                    s_ready,
  output sbuf_pkg::capture_stat_t stat,
  sbuf_ram_if.client              mem
);

  logic              enable;
  logic              armed;
  logic              trigger_q;
  logic              wrap_toggle;
  logic              accept;
  logic              at_end;
  sbuf_pkg::offset_t wr_addr;

  assign accept = s_valid & enable;
  assign at_end = (wr_addr >= ctrl.end_offset);  // Also catches an address past a lowered end

  // External trigger pin registered once before use
  always_ff @(posedge stream_in) begin
    if (rst) begin
      trigger_q <= 1'b0;
    end else begin
      trigger_q <= trigger;
    end
  end

  always_ff @(posedge stream_in) begin
    if (rst) begin
      enable      <= 1'b0;
      armed       <= 1'b0;
      wr_addr     <= '0;
      wrap_toggle <= 1'b0;
    end else if (ctrl.update) begin
      if (ctrl.active) begin
        wr_addr <= ctrl.start_offset;
        enable  <= ~ctrl.wait_trigger;
        armed   <= ctrl.wait_trigger;
      end else begin
        enable <= 1'b0;
        armed  <= 1'b0;
      end
    end else begin
      if (armed && trigger_q) begin
        enable <= 1'b1;
        armed  <= 1'b0;
      end
      if (accept) begin
        if (at_end) begin
          wr_addr     <= ctrl.start_offset;
          wrap_toggle <= ~wrap_toggle;
          if (ctrl.one_shot) begin
            enable <= 1'b0;  // Range written exactly once
          end
        end else begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
    end
  end

  assign s_ready = enable;

  // Port B writes at the accepting edge
  assign mem.en    = 1'b1;
  assign mem.we    = accept;
  assign mem.addr  = wr_addr;
  assign mem.wdata = s_data;

  assign stat.stopped     = ~enable;
  assign stat.armed       = armed;
  assign stat.wrap_toggle = wrap_toggle;
  assign stat.addr        = wr_addr;

endmodule

// ==== design/sbuf_tdp_ram.sv ====
`timescale 1ns/1ns
`include "sbuf_params.svh"

module sbuf_tdp_ram (
  input logic           stream_in,
  sbuf_ram_if.ram_port  a,
  sbuf_ram_if.ram_port  b
);

  sbuf_pkg::sample_t ram [`SBUF_DEPTH];

  // Port B wins if both ports write the same word in one cycle
  always_ff @(posedge stream_in) begin
    if (a.en && a.we) begin
      ram[a.addr] <= a.wdata;
    end
    if (b.en && b.we) begin
      ram[b.addr] <= b.wdata;
    end
  end

  // Read before write on a collision
  always_ff @(posedge stream_in) begin
    if (a.en) begin
      a.rdata <= ram[a.addr];
    end
  end

  always_ff @(posedge stream_in) begin
    if (b.en) begin
      b.rdata <= ram[b.addr];
    end
  end

endmodule

// ==== design/sbuf_ram_if.sv ====
`timescale 1ns/1ns

// One port of the dual-port sample RAM
interface sbuf_ram_if;

  logic              en;
  logic              we;
  sbuf_pkg::offset_t addr;
  sbuf_pkg::sample_t wdata;
  sbuf_pkg::sample_t rdata;   // Valid one cycle after en

  modport client (
    output en,
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport ram_port (
    input  en,
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// ==== design/sbuf_pkg.sv ====
`include "sbuf_params.svh"

package sbuf_pkg;

  typedef logic [`SBUF_DATA_W-1:0] sample_t;
  typedef logic [$clog2(`SBUF_DEPTH)-1:0] offset_t;
  typedef logic [`SBUF_REG_ADDR_W-1:0] reg_addr_t;

  // CSR to capture engine with update as a one-cycle pulse
  typedef struct packed {
    logic    update;
    logic    active;
    logic    one_shot;
    logic    wait_trigger;
    offset_t start_offset;
    offset_t end_offset;
  } capture_ctrl_t;

  // From capture engine back to CSR
  typedef struct packed {
    logic    stopped;
    logic    armed;
    logic    wrap_toggle;
    offset_t addr;
  } capture_stat_t;

  // STATUS register layout
  typedef struct packed {
    logic [`SBUF_DATA_W-17:0] rsvd_hi;
    offset_t                  addr;         // Bits 15:8
    logic [4:0]               rsvd_lo;
    logic                     wrap_toggle;  // Bit 2
    logic                     armed;
    logic                     stopped;      // Bit 0
  } status_reg_t;

endpackage

// ==== include/sbuf_params.svh ====
`ifndef SBUF_PARAMS_SVH
`define SBUF_PARAMS_SVH

// Buffer geometry
`define SBUF_DEPTH 256
`define SBUF_DATA_W 32

// Top address bit selects the buffer window
`define SBUF_REG_ADDR_W 10

// Register numbers within the register window
`define SBUF_REG_CONTROL 0  // bit 0 active, bit 1 one_shot, bit 2 wait_trigger
`define SBUF_REG_START 1
`define SBUF_REG_END 2
`define SBUF_REG_STATUS 3
`define SBUF_REG_DEPTH 4    // Read only

// Control register bit positions
`define SBUF_CTRL_ACTIVE 0
`define SBUF_CTRL_ONE_SHOT 1
`define SBUF_CTRL_WAIT_TRIG 2

`endif
